// File: Bender.yml
package:
  name: y86_fetch_unit

sources:
  - y86_pkg.sv
  - y86_imem.sv
  - y86_fetch_decode.sv
  - y86_pc_counter.sv
  - y86_fetch_ctrl.sv
  - y86_fetch_unit.sv
  - target: test
    files:
      - tb_y86_fetch_unit.sv

// File: all.f
y86_pkg.sv
y86_imem.sv
y86_fetch_decode.sv
y86_pc_counter.sv
y86_fetch_ctrl.sv
y86_fetch_unit.sv
tb_y86_fetch_unit.sv

// File: tb_y86_fetch_unit.sv
module tb_y86_fetch_unit;
    timeunit 1ns;
    timeprecision 1ps;
    import y86_pkg::*;

    typedef struct {
        addr_t       addr;
        logic [79:0] bytes;
        int          len;
        icode_e      icode;
        logic [3:0]  ifun;
        reg_id_t     ra;
        reg_id_t     rb;
        word_t       valc;
        logic        chk_valc;
        addr_t       valp;
        stat_e       stat;
    } row_t;

    logic clk_i, arst_n_i, load_valid_i, load_ready_o, start_i, out_valid_o, out_ready_i;
    logic [IMEM_AW-1:0] load_addr_i;
    logic [7:0] load_data_i;
    addr_t start_pc_i, out_pc_o, out_valp_o;
    icode_e out_icode_o;
    logic [3:0] out_ifun_o;
    reg_id_t out_ra_o, out_rb_o;
    word_t out_valc_o;
    stat_e out_stat_o, last_stat_o;
    logic running_o;
    logic [FETCH_CNT_W-1:0] fetch_count_o;

    row_t        rows[$];
    addr_t       starts[$];
    integer      seed = 32'h1fa3fdb5;
    int          transfers = 0;
    int unsigned cycle_count = 0;
    int unsigned cycle_limit = 0;

    y86_fetch_unit i_y86_fetch_unit (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    task automatic abort_run();
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic report_mismatch(string msg);
        $display("FAIL @ %0t ns: %s", $time, msg);
        abort_run();
    endtask

    // cycle limit follows the table size
    initial begin
        forever begin
            @(posedge clk_i);
            cycle_count++;
            if (cycle_limit != 0 && cycle_count > cycle_limit) begin
                $display("timeout: run did not complete within %0d cycles", cycle_limit);
                abort_run();
            end
        end
    end

    task automatic check_instr(addr_t exp_pc, icode_e exp_icode, logic [3:0] exp_ifun,
                               reg_id_t exp_ra, reg_id_t exp_rb, word_t exp_valc,
                               logic chk_valc, addr_t exp_valp);
        if (out_pc_o !== exp_pc)
            report_mismatch($sformatf("pc got %h exp %h", out_pc_o, exp_pc));
        if (out_icode_o !== exp_icode || out_ifun_o !== exp_ifun)
            report_mismatch($sformatf("icode/ifun got %h/%h exp %h/%h at pc %h",
                                      out_icode_o, out_ifun_o, exp_icode, exp_ifun, exp_pc));
        if (out_ra_o !== exp_ra || out_rb_o !== exp_rb)
            report_mismatch($sformatf("rA/rB got %h/%h exp %h/%h at pc %h",
                                      out_ra_o, out_rb_o, exp_ra, exp_rb, exp_pc));
        if (chk_valc && out_valc_o !== exp_valc)
            report_mismatch($sformatf("valC got %h exp %h", out_valc_o, exp_valc));
        if (out_valp_o !== exp_valp)
            report_mismatch($sformatf("valP got %h exp %h", out_valp_o, exp_valp));
    endtask

    task automatic check_stat(string what, stat_e got, stat_e exp);
        if (got !== exp)
            report_mismatch($sformatf("%s got %0d exp %0d", what, got, exp));
    endtask

    task automatic check_count(logic [FETCH_CNT_W-1:0] exp);
        if (fetch_count_o !== exp)
            report_mismatch($sformatf("fetch_count got %0d exp %0d", fetch_count_o, exp));
    endtask

    task automatic check_flag(string what, logic got, logic exp);
        if (got !== exp)
            report_mismatch($sformatf("%s got %b exp %b", what, got, exp));
    endtask

    task automatic add_row(addr_t addr, logic [79:0] bytes, int len, icode_e icode,
                           logic [3:0] ifun, reg_id_t ra, reg_id_t rb, word_t valc,
                           logic chk_valc, addr_t valp, stat_e stat);
        rows.push_back('{addr, bytes, len, icode, ifun, ra, rb, valc, chk_valc, valp, stat});
    endtask

    // byte 0 of each instruction sits in the low bits
    task automatic build_table();
        add_row('h000, 80'h10, 1, NOP, 0, 4'hF, 4'hF, 0, 0, 'h001, AOK);
        add_row('h001, 80'h0123456789abcdef_f230, 10, IRMOVQ, 0, 4'hF, 4'h2,
                64'h0123456789abcdef, 1, 'h00B, AOK);
        add_row('h00B, 80'h0000000000000008_1340, 10, RMMOVQ, 0, 4'h1, 4'h3, 8, 1, 'h015, AOK);
        add_row('h015, 80'h2361, 2, OPQ, 1, 4'h2, 4'h3, 0, 0, 'h017, AOK);
        add_row('h017, 80'h4fa0, 2, PUSHQ, 0, 4'h4, 4'hF, 0, 0, 'h019, AOK);
        add_row('h019, 80'h5621, 2, CMOVQ, 1, 4'h5, 4'h6, 0, 0, 'h01B, AOK);
        add_row('h01B, 80'h0000000000000040_71, 9, JXX, 1, 4'hF, 4'hF, 'h40, 1, 'h024, AOK);
        add_row('h040, 80'h0000000000000010_7150, 10, MRMOVQ, 0, 4'h7, 4'h1, 'h10, 1, 'h04A, AOK);
        add_row('h04A, 80'h0000000000000060_80, 9, CALL, 0, 4'hF, 4'hF, 'h60, 1, 'h053, AOK);
        add_row('h060, 80'h8fb0, 2, POPQ, 0, 4'h8, 4'hF, 0, 0, 'h062, AOK);
        add_row('h062, 80'h00, 1, HALT, 0, 4'hF, 4'hF, 0, 0, 'h063, HLT);
        add_row('h080, 80'h10, 1, NOP, 0, 4'hF, 4'hF, 0, 0, 'h081, AOK);
        add_row('h081, 80'h90, 1, RET, 0, 4'hF, 4'hF, 0, 0, 'h082, AOK);
        add_row('h090, 80'hc0, 1, icode_e'(4'hC), 0, 4'hF, 4'hF, 0, 0, 'h091, INS);
        // constant of the last row runs past the end of memory
        add_row('h3FC, 80'h2211f330, 4, IRMOVQ, 0, 4'hF, 4'h3, 64'h2211, 1, 'h406, ADR);
        starts = '{'h000, 'h080, 'h090, 'h3FC, 'h040};
    endtask

    function automatic int find_row(addr_t pc);
        foreach (rows[i])
            if (rows[i].addr == pc) return i;
        return -1;
    endfunction

    function automatic logic is_stop(row_t r);
        return (r.stat != AOK) || (r.icode == RET);
    endfunction

    // jumps and calls follow valC
    function automatic addr_t predicted_next(row_t r);
        return (r.icode == JXX || r.icode == CALL) ? r.valc : r.valp;
    endfunction

    function automatic int stream_length(addr_t start_pc);
        int   idx;
        int   n;
        logic stop;
        n = 0;
        stop = 0;
        idx = find_row(start_pc);
        while (!stop && idx >= 0) begin
            n++;
            stop = is_stop(rows[idx]);
            idx = find_row(predicted_next(rows[idx]));
        end
        return n;
    endfunction

    task automatic write_byte(addr_t addr, logic [7:0] data);
        logic rdy;
        load_valid_i = 1'b1;
        load_addr_i  = addr[IMEM_AW-1:0];
        load_data_i  = data;
        forever begin
            rdy = load_ready_o;
            @(posedge clk_i);
            #1;
            if (rdy) break;
        end
        load_valid_i = 1'b0;
    endtask

    task automatic run_stream(addr_t start_pc);
        addr_t                  exp_pc;
        row_t                   r;
        int                     idx;
        logic                   done;
        integer                 rnd;
        logic [FETCH_CNT_W-1:0] exp_count;
        exp_pc = start_pc;
        done   = 1'b0;
        check_flag("load_ready before start", load_ready_o, 1'b1);
        start_i    = 1'b1;
        start_pc_i = start_pc;
        @(posedge clk_i);
        #1;
        start_i = 1'b0;
        check_flag("valid one cycle after start", out_valid_o, 1'b1);
        while (!done) begin
            rnd = $random(seed);
            out_ready_i = rnd[0];
            idx = find_row(exp_pc);
            if (idx < 0) begin
                $display("no table row at expected pc %h", exp_pc);
                abort_run();
            end
            r = rows[idx];
            // no bubble between items while the stream runs
            check_flag("valid while streaming", out_valid_o, 1'b1);
            exp_count = FETCH_CNT_W'(transfers) + 1'b1;
            check_count(exp_count);
            check_flag("load_ready while streaming", load_ready_o, 1'b0);
            // compared every stalled cycle, so a held payload must not move
            check_instr(r.addr, r.icode, r.ifun, r.ra, r.rb, r.valc, r.chk_valc, r.valp);
            check_stat("out_stat", out_stat_o, r.stat);
            check_flag("running", running_o, !is_stop(r));
            if (out_ready_i) begin
                transfers++;
                done   = is_stop(r);
                exp_pc = predicted_next(r);
            end
            @(posedge clk_i);
            #1;
        end
        out_ready_i = 1'b0;
        check_flag("running after stop", running_o, 1'b0);
        check_flag("load_ready after stop", load_ready_o, 1'b1);
        check_stat("last_stat", last_stat_o, r.stat);
        check_count(FETCH_CNT_W'(transfers));
        repeat (3) begin
            check_flag("valid while stopped", out_valid_o, 1'b0);
            @(posedge clk_i);
            #1;
        end
    endtask

    initial begin
        int unsigned byte_total;
        int unsigned xfer_total;
        arst_n_i     = 1'b0;
        load_valid_i = 1'b0;
        load_addr_i  = '0;
        load_data_i  = '0;
        start_i      = 1'b0;
        start_pc_i   = '0;
        out_ready_i  = 1'b0;
        build_table();
        byte_total = 0;
        xfer_total = 0;
        foreach (rows[i]) byte_total += rows[i].len;
        foreach (starts[i]) xfer_total += stream_length(starts[i]);
        cycle_limit = 4 * (byte_total + xfer_total) + 200;
        repeat (2) @(posedge clk_i);
        #1;
        arst_n_i = 1'b1;
        check_flag("valid after reset", out_valid_o, 1'b0);
        check_flag("running after reset", running_o, 1'b0);
        check_flag("load_ready after reset", load_ready_o, 1'b1);
        check_stat("last_stat after reset", last_stat_o, AOK);
        check_count('0);
        foreach (rows[i])
            for (int b = 0; b < rows[i].len; b++)
                write_byte(rows[i].addr + addr_t'(b), rows[i].bytes[8*b +: 8]);
        foreach (starts[i]) run_stream(starts[i]);
        $display(">>> PASS");
        $finish;
    end

endmodule

// File: y86_fetch_ctrl.sv
module y86_fetch_ctrl (
    input  logic            clk_i,
    input  logic            arst_n_i,
    input  logic            start_i,
    input  logic            load_valid_i,
    input  y86_pkg::icode_e icode_i,
    input  y86_pkg::stat_e  stat_i,
    input  logic            out_ready_i,
    output logic            load_ready_o,
    output logic            load_pc_o,
    output logic            capture_o,
    output logic            out_valid_o,
    output logic            running_o,
    output y86_pkg::stat_e  last_stat_o
);
    import y86_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   out_valid_q;
    logic   out_valid_d;
    stat_e  last_stat_q;
    logic   start_ok;
    logic   slot_free;
    logic   transfer;
    logic   stop_instr;

    assign transfer  = out_valid_q && out_ready_i;
    assign slot_free = !out_valid_q || out_ready_i;

    // a load in the same cycle blocks the start
    assign start_ok  = (state_q == IDLE) && start_i && !load_valid_i;

    // ret target is unknown here, faults and halt end the stream too
    assign stop_instr = (stat_i != AOK) || (icode_i == RET);

    assign load_pc_o = start_ok;

    always_comb begin
        unique case (state_q)
            IDLE:    capture_o = start_ok;
            RUN:     capture_o = slot_free;
            default: capture_o = 1'b0;
        endcase
    end

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE: begin
                if (start_ok) begin
                    state_d = stop_instr ? DRAIN : RUN;
                end
            end
            RUN: begin
                if (capture_o && stop_instr) begin
                    state_d = DRAIN;
                end
            end
            default: begin
                // wait for the stop instruction to leave
                if (transfer) begin
                    state_d = IDLE;
                end
            end
        endcase
    end

    // output slot fills on capture, empties on transfer
    assign out_valid_d = capture_o ? 1'b1 : (transfer ? 1'b0 : out_valid_q);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q     <= IDLE;
            out_valid_q <= 1'b0;
            last_stat_q <= AOK;
        end else begin
            state_q     <= state_d;
            out_valid_q <= out_valid_d;
            if (capture_o) begin
                last_stat_q <= stat_i;
            end
        end
    end

    assign load_ready_o = (state_q == IDLE);
    assign running_o    = (state_q == RUN);
    assign out_valid_o  = out_valid_q;
    assign last_stat_o  = last_stat_q;

endmodule

// File: y86_fetch_decode.sv
module y86_fetch_decode (
    input  y86_pkg::addr_t      pc_i,
    input  y86_pkg::instr_win_t win_i,
    output y86_pkg::icode_e     icode_o,
    output logic [3:0]          ifun_o,
    output y86_pkg::reg_id_t    ra_o,
    output y86_pkg::reg_id_t    rb_o,
    output y86_pkg::word_t      valc_o,
    output y86_pkg::addr_t      valp_o,
    output y86_pkg::addr_t      next_pc_o,
    output y86_pkg::stat_e      stat_o
);
    import y86_pkg::*;

    icode_e     icode;
    logic       need_regids;
    logic       need_valc;
    logic [3:0] length;
    addr_t      end_addr;
    logic       bad_addr;
    logic       bad_icode;

    // opcode nibble may hold C..F, which is flagged below
    assign icode   = icode_e'(win_i[7:4]);
    assign icode_o = icode;
    assign ifun_o  = win_i[3:0];

    assign need_regids = instr_needs_regids(icode);
    assign need_valc   = instr_needs_valc(icode);

    // byte 1 is rA in the high nibble, rB in the low one
    assign ra_o = need_regids ? reg_id_t'(win_i[15:12]) : REG_NONE;
    assign rb_o = need_regids ? reg_id_t'(win_i[11:8]) : REG_NONE;

    // constant is little endian, shifted by the register byte if present
    assign valc_o = need_regids ? win_i[79:16] : win_i[71:8];

    // 1, 2, 9 or 10 bytes
    assign length = 4'd1 + {3'b000, need_regids} + (need_valc ? 4'd8 : 4'd0);
    assign valp_o = pc_i + addr_t'(length);

    // jumps and calls are predicted taken
    assign next_pc_o = instr_predict_taken(icode) ? valc_o : valp_o;

    // last byte of the instruction must still be inside memory
    assign end_addr  = pc_i + addr_t'(length);
    assign bad_addr  = (pc_i >= addr_t'(IMEM_BYTES)) ||
                       (end_addr > addr_t'(IMEM_BYTES));
    assign bad_icode = (win_i[7:4] > POPQ);

    // address fault wins over opcode fault
    always_comb begin
        if (bad_addr) begin
            stat_o = ADR;
        end else if (bad_icode) begin
            stat_o = INS;
        end else if (icode == HALT) begin
            stat_o = HLT;
        end else begin
            stat_o = AOK;
        end
    end

endmodule

// File: y86_fetch_unit.sv
module y86_fetch_unit (
    input  logic                            clk_i,
    input  logic                            arst_n_i,
    // instruction memory load port
    input  logic                            load_valid_i,
    output logic                            load_ready_o,
    input  logic [y86_pkg::IMEM_AW-1:0]     load_addr_i,
    input  logic [7:0]                      load_data_i,
    // start
    input  logic                            start_i,
    input  y86_pkg::addr_t                  start_pc_i,
    // decoded instruction stream
    output logic                            out_valid_o,
    input  logic                            out_ready_i,
    output y86_pkg::addr_t                  out_pc_o,
    output y86_pkg::icode_e                 out_icode_o,
    output logic [3:0]                      out_ifun_o,
    output y86_pkg::reg_id_t                out_ra_o,
    output y86_pkg::reg_id_t                out_rb_o,
    output y86_pkg::word_t                  out_valc_o,
    output y86_pkg::addr_t                  out_valp_o,
    output y86_pkg::stat_e                  out_stat_o,
    // observation
    output logic                            running_o,
    output y86_pkg::stat_e                  last_stat_o,
    output logic [y86_pkg::FETCH_CNT_W-1:0] fetch_count_o
);
    import y86_pkg::*;

    addr_t      pc;
    instr_win_t win;
    icode_e     dec_icode;
    logic [3:0] dec_ifun;
    reg_id_t    dec_ra;
    reg_id_t    dec_rb;
    word_t      dec_valc;
    addr_t      dec_valp;
    addr_t      dec_next_pc;
    stat_e      dec_stat;
    logic       load_pc;
    logic       capture;
    logic       mem_wr_en;

    // one byte per load handshake
    assign mem_wr_en = load_valid_i && load_ready_o;

    y86_imem i_imem (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .wr_en_i   (mem_wr_en),
        .wr_addr_i (load_addr_i),
        .wr_data_i (load_data_i),
        .rd_addr_i (pc),
        .rd_win_o  (win)
    );

    y86_fetch_decode i_fetch_decode (
        .pc_i      (pc),
        .win_i     (win),
        .icode_o   (dec_icode),
        .ifun_o    (dec_ifun),
        .ra_o      (dec_ra),
        .rb_o      (dec_rb),
        .valc_o    (dec_valc),
        .valp_o    (dec_valp),
        .next_pc_o (dec_next_pc),
        .stat_o    (dec_stat)
    );

    y86_pc_counter i_pc_counter (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .load_pc_i     (load_pc),
        .start_pc_i    (start_pc_i),
        .advance_i     (capture),
        .next_pc_i     (dec_next_pc),
        .pc_o          (pc),
        .fetch_count_o (fetch_count_o)
    );

    y86_fetch_ctrl i_fetch_ctrl (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .start_i      (start_i),
        .load_valid_i (load_valid_i),
        .icode_i      (dec_icode),
        .stat_i       (dec_stat),
        .out_ready_i  (out_ready_i),
        .load_ready_o (load_ready_o),
        .load_pc_o    (load_pc),
        .capture_o    (capture),
        .out_valid_o  (out_valid_o),
        .running_o    (running_o),
        .last_stat_o  (last_stat_o)
    );

    // output slot, held while the consumer stalls
    always_ff @(posedge clk_i) begin
        if (capture) begin
            out_pc_o    <= pc;
            out_icode_o <= dec_icode;
            out_ifun_o  <= dec_ifun;
            out_ra_o    <= dec_ra;
            out_rb_o    <= dec_rb;
            out_valc_o  <= dec_valc;
            out_valp_o  <= dec_valp;
            out_stat_o  <= dec_stat;
        end
    end

endmodule

// File: y86_imem.sv
module y86_imem (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  logic                        wr_en_i,
    input  logic [y86_pkg::IMEM_AW-1:0] wr_addr_i,
    input  logic [7:0]                  wr_data_i,
    input  y86_pkg::addr_t              rd_addr_i,
    output y86_pkg::instr_win_t         rd_win_o
);
    import y86_pkg::*;

    // byte storage, lowest address first
    logic [7:0] mem_q [IMEM_BYTES];

    // no writes land while reset is held
    always_ff @(posedge clk_i) begin
        if (wr_en_i && arst_n_i) begin
            mem_q[wr_addr_i] <= wr_data_i;
        end
    end

    // ten-byte window starting at the read address
    for (genvar i = 0; i < MAX_INSTR_BYTES; i++) begin : g_win
        addr_t byte_addr;
        logic  in_range;

        assign byte_addr = rd_addr_i + addr_t'(i);
        assign in_range  = (byte_addr < addr_t'(IMEM_BYTES));

        // past the end reads as zero
        assign rd_win_o[8*i +: 8] = in_range ? mem_q[byte_addr[IMEM_AW-1:0]] : 8'h00;
    end

endmodule

// File: y86_pc_counter.sv
module y86_pc_counter (
    input  logic                            clk_i,
    input  logic                            arst_n_i,
    input  logic                            load_pc_i,
    input  y86_pkg::addr_t                  start_pc_i,
    input  logic                            advance_i,
    input  y86_pkg::addr_t                  next_pc_i,
    output y86_pkg::addr_t                  pc_o,
    output logic [y86_pkg::FETCH_CNT_W-1:0] fetch_count_o
);
    import y86_pkg::*;

    addr_t                  pc_q;
    logic [FETCH_CNT_W-1:0] count_q;

    // start address goes straight to memory in its own cycle
    assign pc_o = load_pc_i ? start_pc_i : pc_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= '0;
        end else if (advance_i) begin
            // next_pc already follows whichever pc was shown
            pc_q <= next_pc_i;
        end else if (load_pc_i) begin
            pc_q <= start_pc_i;
        end
    end

    // counts every capture since reset
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            count_q <= '0;
        end else if (advance_i) begin
            count_q <= count_q + 1'b1;
        end
    end

    assign fetch_count_o = count_q;

endmodule

// File: y86_pkg.sv
package y86_pkg;

    // instruction memory geometry
    localparam int unsigned IMEM_BYTES      = 1024;
    localparam int unsigned IMEM_AW         = $clog2(IMEM_BYTES);

    // longest y86 instruction is ten bytes
    localparam int unsigned MAX_INSTR_BYTES = 10;

    // width of the captured-instruction counter
    localparam int unsigned FETCH_CNT_W     = 32;

    typedef logic [63:0] addr_t;
    typedef logic [63:0] word_t;
    typedef logic [3:0]  reg_id_t;

    // register id meaning no register
    localparam reg_id_t REG_NONE = 4'hF;

    // opcode in the high nibble of byte 0
    typedef enum logic [3:0] {
        HALT   = 4'h0,
        NOP    = 4'h1,
        CMOVQ  = 4'h2,
        IRMOVQ = 4'h3,
        RMMOVQ = 4'h4,
        MRMOVQ = 4'h5,
        OPQ    = 4'h6,
        JXX    = 4'h7,
        CALL   = 4'h8,
        RET    = 4'h9,
        PUSHQ  = 4'hA,
        POPQ   = 4'hB
    } icode_e;

    // y86 status codes
    typedef enum logic [1:0] {
        AOK = 2'd0,
        HLT = 2'd1,
        ADR = 2'd2,
        INS = 2'd3
    } stat_e;

    // byte 0 sits in the low eight bits
    typedef logic [MAX_INSTR_BYTES*8-1:0] instr_win_t;

    // opcodes carrying a register specifier byte
    function automatic logic instr_needs_regids(icode_e op);
        return op inside {CMOVQ, IRMOVQ, RMMOVQ, MRMOVQ, OPQ, PUSHQ, POPQ};
    endfunction

    // opcodes carrying an 8-byte constant
    function automatic logic instr_needs_valc(icode_e op);
        return op inside {IRMOVQ, RMMOVQ, MRMOVQ, JXX, CALL};
    endfunction

    // control transfers predicted taken
    function automatic logic instr_predict_taken(icode_e op);
        return op inside {JXX, CALL};
    endfunction

endpackage
